// File: source/rab_cfg.svh
// remapping block configuration

`ifndef RAB_CFG_SVH
`define RAB_CFG_SVH

// slices and address widths
`define RAB_N_SLICES    4
`define RAB_VADDR_W     32
`define RAB_PADDR_W     40
`define RAB_ID_W        8

// register bus
`define RAB_CFG_ADDR_W  6   // word address
`define RAB_CFG_DATA_W  64

`define RAB_MISS_DEPTH  4   // miss records held
`define RAB_SIZE_W      3   // byte offset bits in a 64-bit beat

`endif

// File: source/rab_pkg.sv
// remapping block types

`default_nettype none

`include "rab_cfg.svh"

package rab_pkg;

  typedef logic [`RAB_VADDR_W-1:0]    vaddr_t;
  typedef logic [`RAB_PADDR_W-1:0]    paddr_t;
  typedef logic [`RAB_ID_W-1:0]       axi_id_t;
  typedef logic [`RAB_CFG_ADDR_W-1:0] cfg_addr_t;
  typedef logic [`RAB_CFG_DATA_W-1:0] cfg_data_t;

  // one address window
  typedef struct packed {
    vaddr_t start_addr;
    vaddr_t end_addr;   // inclusive
    paddr_t offset;     // physical base of the window
    logic   en;
    logic   rd_en;
    logic   wr_en;
  } slice_t;

  typedef slice_t [`RAB_N_SLICES-1:0] slice_arr_t;

  // field order matches the word 0 read layout
  typedef struct packed {
    logic    port;  // 1 for port 1
    axi_id_t id;
    vaddr_t  addr;
  } miss_rec_t;

endpackage

`default_nettype wire

// File: source/rab_ifs.sv
// remapping block interfaces

`timescale 1ns/100ps
`default_nettype none

// selected request, arbiter to FSM and matcher
interface rab_lookup_if;
  import rab_pkg::*;

  logic    req;
  logic    from_p1;
  logic    rw;        // 1 for write
  axi_id_t id;
  vaddr_t  addr_min;
  vaddr_t  addr_max;  // last byte of the burst
  logic    done;

  modport arb (output req, from_p1, rw, id, addr_min, addr_max, input done);
  modport fsm (input req, from_p1, id, addr_min, output done);
  modport match (input addr_min, addr_max, rw);
endinterface

// slice lookup result
interface rab_match_if;
  import rab_pkg::*;

  logic   no_hit;
  logic   multi;
  logic   prot_fail;
  paddr_t out_addr;

  modport src (output no_hit, multi, prot_fail, out_addr);
  modport dst (input no_hit, multi, prot_fail, out_addr);
endinterface

// miss record queue access
interface rab_miss_if;
  import rab_pkg::*;

  logic      push;
  miss_rec_t rec;
  miss_rec_t head;
  logic      empty;
  logic      full;
  logic      pop;

  modport wr (output push, rec);
  modport fifo (input push, rec, pop, output head, empty, full);
  modport rd (input head, empty, output pop);
endinterface

`default_nettype wire

// File: source/rab_port_arbiter.sv
// two port request arbiter

`timescale 1ns/100ps
`default_nettype none

`include "rab_cfg.svh"

module rab_port_arbiter (
  input  logic             Clk_CI,
  input  logic             Rst_RBI,
  input  logic             p1_valid,
  input  rab_pkg::vaddr_t  p1_addr,
  input  rab_pkg::axi_id_t p1_id,
  input  logic [7:0]       p1_len,
  input  logic [2:0]       p1_size,
  input  logic             p1_rw,
  input  logic             p2_valid,
  input  rab_pkg::vaddr_t  p2_addr,
  input  rab_pkg::axi_id_t p2_id,
  input  logic [7:0]       p2_len,
  input  logic [2:0]       p2_size,
  input  logic             p2_rw,
  rab_lookup_if.arb        lookup
);
  import rab_pkg::*;

  localparam int OFS_W = `RAB_SIZE_W;

  logic             sel_p1;
  logic             sel_p1_q;   // selection seen at the sampling edge
  logic             prio_p1;    // low favours port 2
  vaddr_t           addr;
  logic [7:0]       len;
  logic [2:0]       size;
  logic [OFS_W-1:0] ofs_mask;
  vaddr_t           addr_align;
  logic [15:0]      burst_bytes;

  assign sel_p1 = ~p2_valid | (p1_valid & prio_p1);

  assign addr = sel_p1 ? p1_addr : p2_addr;
  assign len  = sel_p1 ? p1_len : p2_len;
  assign size = sel_p1 ? p1_size : p2_size;

  // byte offset bits below the beat size
  assign ofs_mask    = (OFS_W'(1) << size) - OFS_W'(1);
  assign addr_align  = {addr[`RAB_VADDR_W-1:OFS_W], addr[OFS_W-1:0] & ~ofs_mask};
  assign burst_bytes = (16'(len) + 16'd1) << size;

  assign lookup.req      = p1_valid | p2_valid;
  assign lookup.from_p1  = sel_p1;
  assign lookup.rw       = sel_p1 ? p1_rw : p2_rw;
  assign lookup.id       = sel_p1 ? p1_id : p2_id;
  assign lookup.addr_min = addr;
  assign lookup.addr_max = addr_align + vaddr_t'(burst_bytes) - vaddr_t'(1);

  // answer comes one cycle after sampling, so sel_p1_q names the served port
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      prio_p1  <= 1'b0;
      sel_p1_q <= 1'b0;
    end
    else
    begin
      sel_p1_q <= sel_p1;
      if (lookup.done)
        prio_p1 <= ~sel_p1_q;  // favour the port that waited
    end
  end

endmodule

`default_nettype wire

// File: source/rab_slice_match.sv
// slice range match

`timescale 1ns/100ps
`default_nettype none

`include "rab_cfg.svh"

module rab_slice_match (
  input  rab_pkg::slice_arr_t slices,
  rab_lookup_if.match         lookup,
  rab_match_if.src            match
);
  import rab_pkg::*;

  localparam int N = `RAB_N_SLICES;

  logic [N-1:0] hit;
  logic [N-1:0] perm_ok;
  logic         multi;
  paddr_t       xlate;

  always_comb
  begin
    for (int i = 0; i < N; i++)
    begin
      // whole burst must lie inside the window
      hit[i] = slices[i].en &&
               (slices[i].start_addr <= lookup.addr_min) &&
               (lookup.addr_max <= slices[i].end_addr);
      perm_ok[i] = lookup.rw ? slices[i].wr_en : slices[i].rd_en;
    end
  end

  assign multi = |(hit & (hit - N'(1)));  // more than one bit set

  always_comb
  begin
    xlate = '0;
    for (int i = 0; i < N; i++)
    begin
      if (hit[i])
        xlate = paddr_t'(lookup.addr_min - slices[i].start_addr) + slices[i].offset;
    end
  end

  assign match.no_hit    = ~|hit;
  assign match.multi     = multi;
  assign match.prot_fail = ~multi & |(hit & ~perm_ok);
  assign match.out_addr  = xlate;

endmodule

`default_nettype wire

// File: source/rab_xlate_fsm.sv
// translation request FSM

`timescale 1ns/100ps
`default_nettype none

module rab_xlate_fsm (
  input  logic            Clk_CI,
  input  logic            Rst_RBI,
  rab_lookup_if.fsm       lookup,
  rab_match_if.dst        match,
  rab_miss_if.wr          miss,
  input  logic            p1_sent,
  input  logic            p2_sent,
  output logic            p1_accept,
  output logic            p1_drop,
  output logic            p2_accept,
  output logic            p2_drop,
  output rab_pkg::paddr_t out_addr,
  output logic            int_miss,
  output logic            int_multi,
  output logic            int_prot
);
  import rab_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_ANSWER, ST_WAIT} state_t;

  state_t state_q;
  state_t state_d;
  logic   sample;
  logic   sent;
  logic   p1_q;     // served port
  logic   ok_q;
  logic   miss_q;
  logic   multi_q;
  logic   prot_q;
  paddr_t out_addr_q;

  assign sample = (state_q == ST_IDLE) && lookup.req;
  assign sent   = p1_q ? p1_sent : p2_sent;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      ST_IDLE:
        if (lookup.req)
          state_d = ST_ANSWER;
      ST_ANSWER:
        state_d = ok_q ? ST_WAIT : ST_IDLE;
      ST_WAIT:
        if (sent)
          state_d = ST_IDLE;   // requester took the address
      default:
        state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      state_q <= ST_IDLE;
      p1_q    <= 1'b0;
      ok_q    <= 1'b0;
      miss_q  <= 1'b0;
      multi_q <= 1'b0;
      prot_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (sample)
      begin
        p1_q    <= lookup.from_p1;
        miss_q  <= match.no_hit;
        multi_q <= match.multi;
        prot_q  <= match.prot_fail;
        ok_q    <= ~(match.no_hit | match.multi | match.prot_fail);
      end
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (sample)
      out_addr_q <= match.out_addr;
  end

  assign lookup.done = (state_q == ST_ANSWER);

  assign p1_accept = lookup.done & ok_q & p1_q;
  assign p1_drop   = lookup.done & ~ok_q & p1_q;
  assign p2_accept = lookup.done & ok_q & ~p1_q;
  assign p2_drop   = lookup.done & ~ok_q & ~p1_q;
  assign out_addr  = out_addr_q;

  assign int_miss  = lookup.done & miss_q;
  assign int_multi = lookup.done & multi_q;
  assign int_prot  = lookup.done & prot_q;

  // record lands in the queue at the edge the drop appears
  assign miss.push = sample & match.no_hit;
  assign miss.rec  = '{port: lookup.from_p1, id: lookup.id, addr: lookup.addr_min};

  // a drop carries exactly one cause
  a_one_cause: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (p1_drop || p2_drop) |-> $onehot({int_miss, int_multi, int_prot}));

  // answer follows sampling by exactly one cycle
  a_done_timing: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    lookup.done |-> $past(state_q) == ST_IDLE && $past(lookup.req));

endmodule

`default_nettype wire

// File: source/rab_miss_fifo.sv
// miss record queue

`timescale 1ns/100ps
`default_nettype none

`include "rab_cfg.svh"

module rab_miss_fifo (
  input  logic     Clk_CI,
  input  logic     Rst_RBI,
  rab_miss_if.fifo miss
);
  import rab_pkg::*;

  localparam int DEPTH = `RAB_MISS_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  miss_rec_t        mem [0:DEPTH-1];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign do_push    = miss.push & ~miss.full;   // overflow is lost
  assign do_pop     = miss.pop & ~miss.empty;
  assign miss.full  = (count == CNT_W'(DEPTH));
  assign miss.empty = (count == '0);
  assign miss.head  = mem[rd_ptr];

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= next_ptr(wr_ptr);
      if (do_pop)
        rd_ptr <= next_ptr(rd_ptr);
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (do_push)
      mem[wr_ptr] <= miss.rec;
  end

  // count stays within depth, pointers meet only when empty or full
  a_count_ptrs: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    (count <= CNT_W'(DEPTH)) && ((miss.full || miss.empty) == (wr_ptr == rd_ptr)));

endmodule

`default_nettype wire

// File: source/rab_regfile.sv
// configuration register file

`timescale 1ns/100ps
`default_nettype none

`include "rab_cfg.svh"

module rab_regfile (
  input  logic                Clk_CI,
  input  logic                Rst_RBI,
  input  logic                cfg_req,
  input  logic                cfg_we,
  input  rab_pkg::cfg_addr_t  cfg_addr,
  input  rab_pkg::cfg_data_t  cfg_wdata,
  output logic                cfg_ack,
  output rab_pkg::cfg_data_t  cfg_rdata,
  output rab_pkg::slice_arr_t slices,
  rab_miss_if.rd              miss
);
  import rab_pkg::*;

  localparam int SW_W  = `RAB_CFG_ADDR_W - 2;
  localparam int IDX_W = (`RAB_N_SLICES > 1) ? $clog2(`RAB_N_SLICES) : 1;
  localparam int PAD_W = `RAB_CFG_DATA_W - 1 - $bits(miss_rec_t);

  logic             req_q;
  logic             access;
  logic [SW_W-1:0]  slice_word;  // group of four words, 0 is status
  logic [IDX_W-1:0] slice_idx;
  logic [1:0]       field;
  logic             slice_sel;
  cfg_data_t        rd_word;
  slice_arr_t       slices_q;

  assign access     = req_q & ~cfg_ack;   // once per handshake
  assign slice_word = cfg_addr[`RAB_CFG_ADDR_W-1:2];
  assign slice_idx  = IDX_W'(slice_word - SW_W'(1));
  assign field      = cfg_addr[1:0];
  assign slice_sel  = (slice_word != '0) && (slice_word <= SW_W'(`RAB_N_SLICES));

  always_comb
  begin
    rd_word = '0;
    if (cfg_addr == '0)
    begin
      if (!miss.empty)
        rd_word = {1'b1, PAD_W'(0), miss.head};
    end
    else if (slice_sel)
    begin
      case (field)
        2'd0:    rd_word = cfg_data_t'(slices_q[slice_idx].start_addr);
        2'd1:    rd_word = cfg_data_t'(slices_q[slice_idx].end_addr);
        2'd2:    rd_word = cfg_data_t'(slices_q[slice_idx].offset);
        default: rd_word = cfg_data_t'({slices_q[slice_idx].wr_en,
                                        slices_q[slice_idx].rd_en,
                                        slices_q[slice_idx].en});
      endcase
    end
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      req_q    <= 1'b0;
      cfg_ack  <= 1'b0;
      slices_q <= '0;
    end
    else
    begin
      req_q <= cfg_req;
      if (access)
      begin
        cfg_ack <= 1'b1;
        if (cfg_we && slice_sel)
        begin
          case (field)
            2'd0: slices_q[slice_idx].start_addr <= vaddr_t'(cfg_wdata);
            2'd1: slices_q[slice_idx].end_addr   <= vaddr_t'(cfg_wdata);
            2'd2: slices_q[slice_idx].offset     <= paddr_t'(cfg_wdata);
            default:
            begin
              slices_q[slice_idx].en    <= cfg_wdata[0];
              slices_q[slice_idx].rd_en <= cfg_wdata[1];
              slices_q[slice_idx].wr_en <= cfg_wdata[2];
            end
          endcase
        end
      end
      else if (!req_q)
        cfg_ack <= 1'b0;   // host released the request
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (access && !cfg_we)
      cfg_rdata <= rd_word;
  end

  // reading the status word consumes the head record
  assign miss.pop = access & ~cfg_we & (cfg_addr == '0);
  assign slices   = slices_q;

  a_ack_after_req: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    $rose(cfg_ack) |-> $past(cfg_req));

endmodule

`default_nettype wire

// File: source/rab_top.sv
// address remapping block top

`timescale 1ns/100ps
`default_nettype none

module rab_top (
  input  logic               Clk_CI,
  input  logic               Rst_RBI,
  input  logic               p1_valid,
  input  rab_pkg::vaddr_t    p1_addr,
  input  rab_pkg::axi_id_t   p1_id,
  input  logic [7:0]         p1_len,
  input  logic [2:0]         p1_size,
  input  logic               p1_rw,
  input  logic               p1_sent,
  output logic               p1_accept,
  output logic               p1_drop,
  output rab_pkg::paddr_t    p1_out_addr,
  input  logic               p2_valid,
  input  rab_pkg::vaddr_t    p2_addr,
  input  rab_pkg::axi_id_t   p2_id,
  input  logic [7:0]         p2_len,
  input  logic [2:0]         p2_size,
  input  logic               p2_rw,
  input  logic               p2_sent,
  output logic               p2_accept,
  output logic               p2_drop,
  output rab_pkg::paddr_t    p2_out_addr,
  input  logic               cfg_req,
  input  logic               cfg_we,
  input  rab_pkg::cfg_addr_t cfg_addr,
  input  rab_pkg::cfg_data_t cfg_wdata,
  output logic               cfg_ack,
  output rab_pkg::cfg_data_t cfg_rdata,
  output logic               int_miss,
  output logic               int_multi,
  output logic               int_prot,
  output logic               int_mhr_full
);
  import rab_pkg::*;

  slice_arr_t slices;
  paddr_t     out_addr;   // shared by both ports

  rab_lookup_if lookup_if ();
  rab_match_if  match_if ();
  rab_miss_if   miss_if ();

  rab_port_arbiter u_arbiter (
    .Clk_CI   (Clk_CI),
    .Rst_RBI  (Rst_RBI),
    .p1_valid (p1_valid),
    .p1_addr  (p1_addr),
    .p1_id    (p1_id),
    .p1_len   (p1_len),
    .p1_size  (p1_size),
    .p1_rw    (p1_rw),
    .p2_valid (p2_valid),
    .p2_addr  (p2_addr),
    .p2_id    (p2_id),
    .p2_len   (p2_len),
    .p2_size  (p2_size),
    .p2_rw    (p2_rw),
    .lookup   (lookup_if.arb)
  );

  rab_slice_match u_match (
    .slices (slices),
    .lookup (lookup_if.match),
    .match  (match_if.src)
  );

  rab_xlate_fsm u_fsm (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .lookup    (lookup_if.fsm),
    .match     (match_if.dst),
    .miss      (miss_if.wr),
    .p1_sent   (p1_sent),
    .p2_sent   (p2_sent),
    .p1_accept (p1_accept),
    .p1_drop   (p1_drop),
    .p2_accept (p2_accept),
    .p2_drop   (p2_drop),
    .out_addr  (out_addr),
    .int_miss  (int_miss),
    .int_multi (int_multi),
    .int_prot  (int_prot)
  );

  rab_miss_fifo u_miss_fifo (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .miss    (miss_if.fifo)
  );

  rab_regfile u_regfile (
    .Clk_CI    (Clk_CI),
    .Rst_RBI   (Rst_RBI),
    .cfg_req   (cfg_req),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_ack   (cfg_ack),
    .cfg_rdata (cfg_rdata),
    .slices    (slices),
    .miss      (miss_if.rd)
  );

  assign p1_out_addr  = out_addr;
  assign p2_out_addr  = out_addr;
  assign int_mhr_full = miss_if.full;

endmodule

`default_nettype wire

// File: testbench/tb_rab.sv
// remapping block testbench

`timescale 1ns/100ps
`default_nettype none

`include "rab_cfg.svh"

module tb_rab;
  import rab_pkg::*;

  localparam int TIMEOUT_NS  = 20000;  // tests take about 700 cycles of 4 ns
  localparam int ANSWER_WAIT = 50;     // cycles
  localparam int ACK_WAIT    = 20;

  logic      Clk_CI;
  logic      Rst_RBI;
  logic      p1_valid;
  vaddr_t    p1_addr;
  axi_id_t   p1_id;
  logic [7:0] p1_len;
  logic [2:0] p1_size;
  logic      p1_rw;
  logic      p1_sent;
  logic      p1_accept;
  logic      p1_drop;
  paddr_t    p1_out_addr;
  logic      p2_valid;
  vaddr_t    p2_addr;
  axi_id_t   p2_id;
  logic [7:0] p2_len;
  logic [2:0] p2_size;
  logic      p2_rw;
  logic      p2_sent;
  logic      p2_accept;
  logic      p2_drop;
  paddr_t    p2_out_addr;
  logic      cfg_req;
  logic      cfg_we;
  cfg_addr_t cfg_addr;
  cfg_data_t cfg_wdata;
  logic      cfg_ack;
  cfg_data_t cfg_rdata;
  logic      int_miss;
  logic      int_multi;
  logic      int_prot;
  logic      int_mhr_full;

  integer    seed = 46;
  string     cur_test;
  int        test_count = 0;
  int        check_count = 0;
  int        err_count = 0;
  int        test_errs;
  int        got_cycles;   // negedges from driving to the answer
  logic      a1, d1, a2, d2;
  logic      irq_miss, irq_multi, irq_prot;
  cfg_data_t exp_words [0:63];

  rab_top UUT (.*);

  initial
  begin
    Clk_CI = 1'b0;
    forever #2 Clk_CI = ~Clk_CI;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("watchdog: run did not finish within %0d ns", TIMEOUT_NS);
    $display("Simulation failed");
    $finish;
  end

  task automatic check_bit(input string what, input logic exp, input logic act);
    check_count++;
    if (act !== exp)
    begin
      err_count++;
      $display("FAIL %s %s: expected %0b, actual %0b", cur_test, what, exp, act);
    end
  endtask

  task automatic check_paddr(input string what, input paddr_t exp, input paddr_t act);
    check_count++;
    if (act !== exp)
    begin
      err_count++;
      $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic check_cfg_data(input string what, input cfg_data_t exp, input cfg_data_t act);
    check_count++;
    if (act !== exp)
    begin
      err_count++;
      $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    err_count++;
    $display("ERROR %s: %s", cur_test, msg);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_errs = err_count;
    test_count++;
  endtask

  task automatic end_test();
    $display("test %s finished with %0d errors", cur_test, err_count - test_errs);
  endtask

  // word 0 layout of a valid miss record
  function automatic cfg_data_t miss_word(input vaddr_t addr, input axi_id_t id,
                                          input logic from_p1);
    cfg_data_t w;
    w = '0;
    w[31:0]  = addr;
    w[39:32] = id;
    w[40]    = from_p1;
    w[63]    = 1'b1;
    return w;
  endfunction

  task automatic apply_reset();
    Rst_RBI = 1'b0;
    repeat (16) @(negedge Clk_CI);
    Rst_RBI = 1'b1;
  endtask

  task automatic drive_port(input int port, input logic valid, input vaddr_t addr,
                            input axi_id_t id, input logic [7:0] len,
                            input logic [2:0] size, input logic rw);
    if (port == 1)
    begin
      p1_valid = valid;
      p1_addr  = addr;
      p1_id    = id;
      p1_len   = len;
      p1_size  = size;
      p1_rw    = rw;
    end
    else
    begin
      p2_valid = valid;
      p2_addr  = addr;
      p2_id    = id;
      p2_len   = len;
      p2_size  = size;
      p2_rw    = rw;
    end
  endtask

  task automatic wait_answer();
    logic seen;
    seen = 1'b0;
    got_cycles = 0;
    while (!seen && got_cycles < ANSWER_WAIT)
    begin
      @(negedge Clk_CI);
      got_cycles++;
      seen = p1_accept | p1_drop | p2_accept | p2_drop;
    end
    if (!seen)
      report_error("no accept or drop within the answer window");
    a1 = p1_accept;
    d1 = p1_drop;
    a2 = p2_accept;
    d2 = p2_drop;
    irq_miss  = int_miss;
    irq_multi = int_multi;
    irq_prot  = int_prot;
  endtask

  // valid goes low in the answer cycle
  task automatic send_req(input int port, input vaddr_t addr, input axi_id_t id,
                          input logic [7:0] len, input logic [2:0] size, input logic rw);
    @(negedge Clk_CI);
    drive_port(port, 1'b1, addr, id, len, size, rw);
    wait_answer();
    drive_port(port, 1'b0, '0, '0, '0, '0, 1'b0);
  endtask

  task automatic pulse_sent(input int port);
    @(negedge Clk_CI);
    if (port == 1)
      p1_sent = 1'b1;
    else
      p2_sent = 1'b1;
    @(negedge Clk_CI);
    p1_sent = 1'b0;
    p2_sent = 1'b0;
  endtask

  task automatic expect_answer(input int port, input logic accept);
    if (port == 1)
    begin
      check_bit("p1_accept", accept, a1);
      check_bit("p1_drop", ~accept, d1);
      check_bit("answer on p2", 1'b0, a2 | d2);
    end
    else
    begin
      check_bit("p2_accept", accept, a2);
      check_bit("p2_drop", ~accept, d2);
      check_bit("answer on p1", 1'b0, a1 | d1);
    end
  endtask

  task automatic wait_cfg_ack(input logic level);
    int n;
    n = 0;
    while (cfg_ack !== level && n < ACK_WAIT)
    begin
      @(negedge Clk_CI);
      n++;
    end
    if (cfg_ack !== level)
      report_error("cfg_ack did not follow cfg_req");
  endtask

  task automatic cfg_write(input cfg_addr_t addr, input cfg_data_t data);
    @(negedge Clk_CI);
    cfg_req   = 1'b1;
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    wait_cfg_ack(1'b1);
    cfg_req = 1'b0;
    cfg_we  = 1'b0;
    wait_cfg_ack(1'b0);
  endtask

  task automatic cfg_read(input cfg_addr_t addr, output cfg_data_t data);
    @(negedge Clk_CI);
    cfg_req  = 1'b1;
    cfg_we   = 1'b0;
    cfg_addr = addr;
    wait_cfg_ack(1'b1);
    data    = cfg_rdata;   // valid while ack is high
    cfg_req = 1'b0;
    wait_cfg_ack(1'b0);
  endtask

  task automatic set_slice(input int s, input vaddr_t start, input vaddr_t last,
                           input paddr_t offset, input logic [2:0] flags);
    cfg_write(cfg_addr_t'(4 + 4 * s), cfg_data_t'(start));
    cfg_write(cfg_addr_t'(5 + 4 * s), cfg_data_t'(last));
    cfg_write(cfg_addr_t'(6 + 4 * s), cfg_data_t'(offset));
    cfg_write(cfg_addr_t'(7 + 4 * s), cfg_data_t'(flags));
  endtask

  task automatic test_reset_values();
    start_test("reset_values");
    check_bit("p1_accept", 1'b0, p1_accept);
    check_bit("p1_drop", 1'b0, p1_drop);
    check_bit("p2_accept", 1'b0, p2_accept);
    check_bit("p2_drop", 1'b0, p2_drop);
    check_bit("int_miss", 1'b0, int_miss);
    check_bit("int_multi", 1'b0, int_multi);
    check_bit("int_prot", 1'b0, int_prot);
    check_bit("cfg_ack", 1'b0, cfg_ack);
    check_bit("int_mhr_full", 1'b0, int_mhr_full);
    end_test();
  endtask

  task automatic test_registers();
    cfg_data_t wdata;
    cfg_data_t rdata;
    start_test("registers");
    for (int w = 4; w < 4 + 4 * `RAB_N_SLICES; w++)
    begin
      wdata = {32'($random(seed)), 32'($random(seed))};
      cfg_write(cfg_addr_t'(w), wdata);
      case (w % 4)
        0, 1:    exp_words[w] = {32'b0, wdata[31:0]};
        2:       exp_words[w] = {24'b0, wdata[39:0]};
        default: exp_words[w] = {61'b0, wdata[2:0]};   // flags
      endcase
    end
    for (int w = 4; w < 4 + 4 * `RAB_N_SLICES; w++)
    begin
      cfg_read(cfg_addr_t'(w), rdata);
      check_cfg_data($sformatf("word %0d", w), exp_words[w], rdata);
    end
    for (int w = 1; w < 4; w++)
    begin
      cfg_read(cfg_addr_t'(w), rdata);
      check_cfg_data($sformatf("word %0d", w), '0, rdata);
    end
    for (int s = 0; s < `RAB_N_SLICES; s++)
      cfg_write(cfg_addr_t'(7 + 4 * s), '0);   // disable again
    end_test();
  endtask

  task automatic test_translate();
    vaddr_t  ofs;
    vaddr_t  addr;
    axi_id_t id;
    paddr_t  offset;
    paddr_t  exp;
    start_test("translate");
    offset = {8'h80, 32'($random(seed))};
    set_slice(0, 32'h1000_0000, 32'h1000_ffff, offset, 3'b111);
    ofs  = 32'($random(seed)) & 32'h0000_0ff8;
    addr = 32'h1000_0000 | ofs;
    id   = 8'($random(seed));
    send_req(1, addr, id, 8'd3, 3'd3, 1'b0);
    expect_answer(1, 1'b1);
    check_bit("answer one cycle after sampling", 1'b1, got_cycles == 1);
    exp = offset + paddr_t'(ofs);
    check_paddr("p1_out_addr", exp, p1_out_addr);
    // port 2 asks while port 1 still holds the address
    drive_port(2, 1'b1, 32'h1000_0800, 8'h33, 8'd0, 3'd3, 1'b0);
    repeat (3)
    begin
      @(negedge Clk_CI);
      check_paddr("p1_out_addr held", exp, p1_out_addr);
      check_bit("no answer while waiting", 1'b0, p1_accept | p1_drop | p2_accept | p2_drop);
    end
    pulse_sent(1);
    wait_answer();
    expect_answer(2, 1'b1);
    check_paddr("p2_out_addr", offset + 40'h800, p2_out_addr);
    drive_port(2, 1'b0, '0, '0, '0, '0, 1'b0);
    pulse_sent(2);
    end_test();
  endtask

  task automatic test_miss();
    axi_id_t   id;
    cfg_data_t rdata;
    start_test("miss");
    id = 8'($random(seed));
    send_req(1, 32'h2000_0040, id, 8'd0, 3'd2, 1'b0);
    expect_answer(1, 1'b0);
    check_bit("int_miss", 1'b1, irq_miss);
    cfg_read('0, rdata);
    check_cfg_data("record", miss_word(32'h2000_0040, id, 1'b1), rdata);
    cfg_read('0, rdata);
    check_bit("valid after pop", 1'b0, rdata[63]);
    // 4 beats of 8 bytes from the aligned 0x1000fff0 pass the slice end
    id = 8'($random(seed));
    send_req(2, 32'h1000_fff4, id, 8'd3, 3'd3, 1'b1);
    expect_answer(2, 1'b0);
    check_bit("int_miss burst", 1'b1, irq_miss);
    cfg_read('0, rdata);
    check_cfg_data("burst record", miss_word(32'h1000_fff4, id, 1'b0), rdata);
    cfg_read('0, rdata);
    check_bit("valid after burst pop", 1'b0, rdata[63]);
    end_test();
  endtask

  task automatic test_faults();
    cfg_data_t rdata;
    start_test("faults");
    set_slice(1, 32'h3000_0000, 32'h3000_ffff, 40'h00_4000_0000, 3'b011);
    send_req(1, 32'h3000_0100, 8'h5a, 8'd0, 3'd3, 1'b1);
    expect_answer(1, 1'b0);
    check_bit("int_prot", 1'b1, irq_prot);
    check_bit("int_miss on prot", 1'b0, irq_miss);
    // two windows overlapping from 0x40008000
    set_slice(2, 32'h4000_0000, 32'h4000_ffff, 40'h00_5000_0000, 3'b111);
    set_slice(3, 32'h4000_8000, 32'h4001_ffff, 40'h00_6000_0000, 3'b111);
    send_req(2, 32'h4000_9000, 8'ha5, 8'd0, 3'd3, 1'b0);
    expect_answer(2, 1'b0);
    check_bit("int_multi", 1'b1, irq_multi);
    check_bit("int_miss on multi", 1'b0, irq_miss);
    cfg_read('0, rdata);
    check_cfg_data("no record logged", '0, rdata);
    end_test();
  endtask

  task automatic test_arbitration();
    start_test("arbitration");
    apply_reset();
    set_slice(0, 32'h1000_0000, 32'h1000_ffff, 40'h80_0000_0000, 3'b111);
    @(negedge Clk_CI);
    drive_port(1, 1'b1, 32'h1000_0100, 8'h11, 8'd0, 3'd3, 1'b0);
    drive_port(2, 1'b1, 32'h1000_0200, 8'h22, 8'd0, 3'd3, 1'b0);
    wait_answer();
    expect_answer(2, 1'b1);   // priority starts at port 2
    check_paddr("p2_out_addr", 40'h80_0000_0200, p2_out_addr);
    drive_port(2, 1'b0, '0, '0, '0, '0, 1'b0);
    pulse_sent(2);
    wait_answer();
    expect_answer(1, 1'b1);
    check_paddr("p1_out_addr", 40'h80_0000_0100, p1_out_addr);
    drive_port(1, 1'b0, '0, '0, '0, '0, 1'b0);
    pulse_sent(1);
    end_test();
  endtask

  task automatic test_queue_full();
    axi_id_t   ids [0:4];
    cfg_data_t rdata;
    start_test("queue_full");
    for (int i = 0; i < 5; i++)
    begin
      ids[i] = 8'($random(seed));
      send_req(1, 32'h5000_0000 + 32'(i) * 32'h100, ids[i], 8'd0, 3'd3, 1'b0);
      expect_answer(1, 1'b0);
    end
    check_bit("int_mhr_full set", 1'b1, int_mhr_full);
    for (int i = 0; i < 4; i++)
    begin
      cfg_read('0, rdata);
      check_cfg_data($sformatf("record %0d", i),
                     miss_word(32'h5000_0000 + 32'(i) * 32'h100, ids[i], 1'b1), rdata);
    end
    cfg_read('0, rdata);
    check_bit("valid after four records", 1'b0, rdata[63]);
    check_bit("int_mhr_full cleared", 1'b0, int_mhr_full);
    end_test();
  endtask

  initial
  begin
    Rst_RBI   = 1'b0;
    p1_sent   = 1'b0;
    p2_sent   = 1'b0;
    cfg_req   = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    drive_port(1, 1'b0, '0, '0, '0, '0, 1'b0);
    drive_port(2, 1'b0, '0, '0, '0, '0, 1'b0);
    apply_reset();
    test_reset_values();
    test_registers();
    test_translate();
    test_miss();
    test_faults();
    test_arbitration();
    test_queue_full();
    $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, err_count);
    if (err_count == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/rab_pkg.sv
source/rab_ifs.sv
source/rab_port_arbiter.sv
source/rab_slice_match.sv
source/rab_xlate_fsm.sv
source/rab_miss_fifo.sv
source/rab_regfile.sv
source/rab_top.sv
testbench/tb_rab.sv

// File: Makefile
# Verilator simulation of the remapping block

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f tb.f --top-module tb_rab -o sim_tb_rab
	@out=$$(./obj_dir/sim_tb_rab); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
